// File: source/exec_pkg.sv
// RV32I subset only (alu, lw/sw, beq/bne/blt/bge, jal), word accesses, no exceptions or CSRs
package exec_pkg;

    localparam int xlen       = 32;          // data and address width
    localparam int reg_addr_w = 5;           // register index width

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl
    } alu_op_e;

    typedef enum logic [2:0] {
        br_beq, br_bne, br_blt, br_bge, br_jal
    } br_kind_e;

    typedef enum logic [1:0] {
        sel_alu, sel_branch, sel_ls, sel_none
    } fu_sel_e;

    // instruction formats, msb first as in the ISA manual
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0]            imm_hi;       // imm[11:5]
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;       // imm[4:0]
        logic [6:0]            opcode;
    } instr_s_t;

    typedef struct packed {
        logic                  imm12;        // sign bit
        logic [5:0]            imm10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;                         // also carries the jal immediate bits
        instr_s_t s;
        instr_b_t b;
    } instr_word_u;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_word_u     instr;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic            pred_taken;
    } issue_pkt_t;

    typedef struct packed {
        fu_sel_e               fu_sel;
        alu_op_e               alu_op;
        br_kind_e              br_kind;
        logic                  is_store;
        logic                  uses_imm;
        logic                  rd_we;        // already false for x0
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;          // sign-extended
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic                  pred_taken;
    } uop_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            ren;
        logic            wen;
    } dmem_req_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            hit;
    } dmem_rsp_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_we;
        logic [xlen-1:0]       wdata;
        logic                  redirect;     // branch or jal mispredicted
        logic [xlen-1:0]       redirect_pc;
        logic                  is_branch;
        logic                  taken;
    } exec_res_t;

endpackage

// File: source/fu_alu.sv
// combinational scalar ALU; shifts use port_b[4:0], slt compares signed
`timescale 1ns/1ns

module fu_alu import exec_pkg::*; (
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] port_a,
    input  logic [xlen-1:0] port_b,
    output logic [xlen-1:0] port_output
);

    logic [4:0] shamt;

    assign shamt = port_b[4:0];              // rv32 shift amount

    always_comb begin
        case (alu_op)
            alu_add: port_output = port_a + port_b;
            alu_sub: port_output = port_a - port_b;
            alu_and: port_output = port_a & port_b;
            alu_or:  port_output = port_a | port_b;
            alu_xor: port_output = port_a ^ port_b;
            alu_slt: port_output = {{(xlen-1){1'b0}}, $signed(port_a) < $signed(port_b)};
            alu_sll: port_output = port_a << shamt;
            alu_srl: port_output = port_a >> shamt;   // logical
            default: port_output = '0;
        endcase
    end

endmodule

// File: source/fu_branch.sv
// branch resolution for beq/bne/blt/bge and jal; target is always pc relative
`timescale 1ns/1ns

module fu_branch import exec_pkg::*; (
    input  br_kind_e        br_kind,
    input  logic [xlen-1:0] reg_a,
    input  logic [xlen-1:0] reg_b,
    input  logic [xlen-1:0] current_pc,
    input  logic [xlen-1:0] imm,
    input  logic            predicted_outcome,
    output logic            branch_outcome,
    output logic [xlen-1:0] branch_target,
    output logic [xlen-1:0] correct_pc,
    output logic            miss,
    output logic [xlen-1:0] jump_wdat
);

    always_comb begin
        case (br_kind)
            br_beq:  branch_outcome = (reg_a == reg_b);
            br_bne:  branch_outcome = (reg_a != reg_b);
            br_blt:  branch_outcome = ($signed(reg_a) < $signed(reg_b));
            br_bge:  branch_outcome = ($signed(reg_a) >= $signed(reg_b));
            br_jal:  branch_outcome = 1'b1;  // unconditional
            default: branch_outcome = 1'b0;
        endcase
    end

    assign branch_target = current_pc + imm;
    assign jump_wdat     = current_pc + 32'd4;   // link value and fall-through
    assign correct_pc    = branch_outcome ? branch_target : jump_wdat;
    assign miss          = (branch_outcome != predicted_outcome);

endmodule

// File: source/fu_scalar_ls.sv
// one word access at a time; address assumed word aligned, request held until hit
`timescale 1ns/1ns

module fu_scalar_ls import exec_pkg::*; (
    input  logic            CLK,
    input  logic            arst_n,
    input  logic            start,
    input  logic            is_store,
    input  logic [xlen-1:0] addr_base,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] store_data,
    input  dmem_rsp_t       dmem_rsp,
    output dmem_req_t       dmem_req,
    output logic            busy,
    output logic            done,
    output logic [xlen-1:0] load_data
);

    typedef enum logic [1:0] {ls_idle, ls_access, ls_finish} ls_state_e;

    ls_state_e       state;
    logic            ren_q, wen_q;
    logic [xlen-1:0] addr_q, wdata_q;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state <= ls_idle;
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else begin
            case (state)
                ls_idle: if (start) begin
                    state <= ls_access;
                    ren_q <= !is_store;
                    wen_q <= is_store;
                end
                ls_access: if (dmem_rsp.hit) begin
                    state <= ls_finish;
                    ren_q <= 1'b0;
                    wen_q <= 1'b0;
                end
                default: state <= ls_idle;   // finish lasts one cycle
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == ls_idle && start) begin
            addr_q  <= addr_base + imm;      // effective address
            wdata_q <= store_data;
        end
        if (state == ls_access && dmem_rsp.hit) load_data <= dmem_rsp.rdata;
    end

    assign dmem_req.addr  = addr_q;
    assign dmem_req.wdata = wdata_q;
    assign dmem_req.ren   = ren_q;
    assign dmem_req.wen   = wen_q;

    assign busy = (state != ls_idle);
    assign done = (state == ls_finish);

endmodule

// File: source/issue_decode.sv
// one-entry decode register; unsupported opcodes or funct codes become no-op uops with no write
`timescale 1ns/1ns

module issue_decode import exec_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       in_valid,
    input  issue_pkt_t in_pkt,
    output logic       in_ready,
    output logic       dec_valid,
    output uop_t       dec_uop,
    input  logic       dec_ready
);

    instr_word_u     iw;
    uop_t            uop_d;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j;
    logic            alt;                    // sub / sra select bit
    logic            alu_ok;
    alu_op_e         alu_sel;
    logic            run;                    // low in the first cycle out of reset

    assign iw = in_pkt.instr;

    assign imm_i = {{20{iw.i.imm12[11]}}, iw.i.imm12};
    assign imm_s = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
    assign imm_b = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
    assign imm_j = {{11{iw.i.imm12[11]}}, iw.i.imm12[11], iw.i.rs1, iw.i.funct3,
                    iw.i.imm12[0], iw.i.imm12[10:1], 1'b0};   // jal bits seen through i view

    // funct7[5] for reg ops; for imm ops only srli/srai look at it, no subi
    assign alt = (iw.r.opcode == op_reg) ? iw.r.funct7[5]
                                         : (iw.i.funct3 == 3'b101) && iw.i.imm12[10];

    always_comb begin
        alu_ok  = 1'b1;
        alu_sel = alu_add;
        case (iw.r.funct3)
            3'b000: alu_sel = alt ? alu_sub : alu_add;
            3'b001: alu_sel = alu_sll;
            3'b010: alu_sel = alu_slt;
            3'b100: alu_sel = alu_xor;
            3'b101: begin
                alu_sel = alu_srl;
                alu_ok  = !alt;              // sra not in the subset
            end
            3'b110: alu_sel = alu_or;
            3'b111: alu_sel = alu_and;
            default: alu_ok = 1'b0;          // sltu
        endcase
    end

    always_comb begin
        uop_d            = '0;
        uop_d.fu_sel     = sel_none;
        uop_d.alu_op     = alu_sel;
        uop_d.br_kind    = br_beq;
        uop_d.rd         = iw.r.rd;
        uop_d.pc         = in_pkt.pc;
        uop_d.rs1_val    = in_pkt.rs1_val;
        uop_d.rs2_val    = in_pkt.rs2_val;
        uop_d.pred_taken = in_pkt.pred_taken;
        case (iw.r.opcode)
            op_reg: begin
                uop_d.fu_sel = alu_ok ? sel_alu : sel_none;
                uop_d.rd_we  = alu_ok;
            end
            op_imm: begin
                uop_d.fu_sel   = alu_ok ? sel_alu : sel_none;
                uop_d.rd_we    = alu_ok;
                uop_d.uses_imm = 1'b1;
                uop_d.imm      = imm_i;
            end
            op_load: begin
                uop_d.fu_sel = (iw.i.funct3 == 3'b010) ? sel_ls : sel_none;   // lw only
                uop_d.rd_we  = (iw.i.funct3 == 3'b010);
                uop_d.imm    = imm_i;
            end
            op_store: begin
                uop_d.fu_sel   = (iw.s.funct3 == 3'b010) ? sel_ls : sel_none; // sw only
                uop_d.is_store = 1'b1;
                uop_d.imm      = imm_s;
            end
            op_branch: begin
                uop_d.fu_sel = sel_branch;
                uop_d.imm    = imm_b;
                case (iw.b.funct3)
                    3'b000:  uop_d.br_kind = br_beq;
                    3'b001:  uop_d.br_kind = br_bne;
                    3'b100:  uop_d.br_kind = br_blt;
                    3'b101:  uop_d.br_kind = br_bge;
                    default: uop_d.fu_sel  = sel_none; // unsigned compares not supported
                endcase
            end
            op_jal: begin
                uop_d.fu_sel  = sel_branch;
                uop_d.br_kind = br_jal;
                uop_d.rd_we   = 1'b1;
                uop_d.imm     = imm_j;
            end
            default: uop_d.fu_sel = sel_none;
        endcase
        if (iw.r.rd == '0) uop_d.rd_we = 1'b0;   // x0 is never written
    end

    assign in_ready = run && (!dec_valid || dec_ready);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            run       <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (in_ready) dec_valid <= in_valid;  // load or drain
        end
    end

    always_ff @(posedge CLK) begin
        if (in_valid && in_ready) dec_uop <= uop_d;
    end

endmodule

// File: source/execute.sv
// alu and branch results are combinational; a load/store blocks the stage until done
`timescale 1ns/1ns

module execute import exec_pkg::*; (
    input  logic      CLK,
    input  logic      arst_n,
    input  logic      dec_valid,
    input  uop_t      dec_uop,
    output logic      dec_ready,
    output logic      ex_valid,
    output exec_res_t ex_res,
    input  logic      ex_ready,
    output dmem_req_t dmem_req,
    input  dmem_rsp_t dmem_rsp
);

    logic [xlen-1:0]       alu_b, alu_out;
    logic                  br_taken, br_miss;
    logic [xlen-1:0]       br_correct_pc, br_link;
    logic                  is_ls, ls_start, ls_busy, ls_done;
    logic [xlen-1:0]       ls_rdata;
    logic [xlen-1:0]       ls_pc;        // held for the running access
    logic [reg_addr_w-1:0] ls_rd;
    logic                  ls_rd_we;

    assign alu_b = dec_uop.uses_imm ? dec_uop.imm : dec_uop.rs2_val;

    fu_alu u_alu (
        .alu_op      (dec_uop.alu_op),
        .port_a      (dec_uop.rs1_val),
        .port_b      (alu_b),
        .port_output (alu_out)
    );

    fu_branch u_branch (
        .br_kind           (dec_uop.br_kind),
        .reg_a             (dec_uop.rs1_val),
        .reg_b             (dec_uop.rs2_val),
        .current_pc        (dec_uop.pc),
        .imm               (dec_uop.imm),
        .predicted_outcome (dec_uop.pred_taken),
        .branch_outcome    (br_taken),
        .branch_target     (),           // already folded into correct_pc
        .correct_pc        (br_correct_pc),
        .miss              (br_miss),
        .jump_wdat         (br_link)
    );

    fu_scalar_ls u_ls (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .start      (ls_start),
        .is_store   (dec_uop.is_store),
        .addr_base  (dec_uop.rs1_val),
        .imm        (dec_uop.imm),
        .store_data (dec_uop.rs2_val),
        .dmem_rsp   (dmem_rsp),
        .dmem_req   (dmem_req),
        .busy       (ls_busy),
        .done       (ls_done),
        .load_data  (ls_rdata)
    );

    assign is_ls     = (dec_uop.fu_sel == sel_ls);
    assign dec_ready = ex_ready && !ls_busy;                 // stall for the whole access
    assign ls_start  = dec_valid && is_ls && dec_ready;      // wb slot is free by done
    assign ex_valid  = ls_done || (dec_valid && !is_ls && !ls_busy);

    always_ff @(posedge CLK) begin
        if (ls_start) begin
            ls_pc    <= dec_uop.pc;
            ls_rd    <= dec_uop.rd;
            ls_rd_we <= dec_uop.rd_we;   // low for stores
        end
    end

    always_comb begin
        ex_res = '0;
        if (ls_done) begin
            ex_res.pc    = ls_pc;
            ex_res.rd    = ls_rd;
            ex_res.rd_we = ls_rd_we;
            ex_res.wdata = ls_rdata;
        end else begin
            ex_res.pc          = dec_uop.pc;
            ex_res.rd          = dec_uop.rd;
            ex_res.rd_we       = dec_uop.rd_we;  // false for no-op uops
            ex_res.is_branch   = (dec_uop.fu_sel == sel_branch);
            ex_res.wdata       = ex_res.is_branch ? br_link : alu_out;
            ex_res.taken       = ex_res.is_branch && br_taken;
            ex_res.redirect    = ex_res.is_branch && br_miss;
            ex_res.redirect_pc = br_correct_pc;
        end
    end

endmodule

// File: source/writeback_select.sv
// completion register; out_res.redirect is forced low whenever out_valid is low
`timescale 1ns/1ns

module writeback_select import exec_pkg::*; (
    input  logic      CLK,
    input  logic      arst_n,
    input  logic      ex_valid,
    input  exec_res_t ex_res,
    output logic      ex_ready,
    output logic      out_valid,
    output exec_res_t out_res,
    input  logic      out_ready
);

    exec_res_t res_q;

    assign ex_ready = !out_valid || out_ready;   // empty or draining

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (ex_ready) begin
            out_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (ex_valid && ex_ready) res_q <= ex_res;
    end

    always_comb begin
        out_res          = res_q;
        out_res.redirect = res_q.redirect && out_valid;   // fetch sees no stale redirect
    end

endmodule

// File: source/exec_top.sv
// execute stage top: decode register, execute units, completion register
`timescale 1ns/1ns

module exec_top import exec_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  issue_pkt_t in_pkt,
    output dmem_req_t  dmem_req,
    input  dmem_rsp_t  dmem_rsp,
    output logic       out_valid,
    input  logic       out_ready,
    output exec_res_t  out_res
);

    logic      dec_valid, dec_ready;
    uop_t      dec_uop;
    logic      ex_valid, ex_ready;
    exec_res_t ex_res;

    issue_decode u_decode (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .in_ready  (in_ready),
        .dec_valid (dec_valid),
        .dec_uop   (dec_uop),
        .dec_ready (dec_ready)
    );

    execute u_execute (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_uop   (dec_uop),
        .dec_ready (dec_ready),
        .ex_valid  (ex_valid),
        .ex_res    (ex_res),
        .ex_ready  (ex_ready),
        .dmem_req  (dmem_req),
        .dmem_rsp  (dmem_rsp)
    );

    writeback_select u_wb (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .ex_valid  (ex_valid),
        .ex_res    (ex_res),
        .ex_ready  (ex_ready),
        .out_valid (out_valid),
        .out_res   (out_res),
        .out_ready (out_ready)
    );

endmodule

// File: tests/exec_top_asserts.sv
// sampled at the rising CLK edge; dmem rules assume a single outstanding access
`timescale 1ns/1ns

module exec_top_asserts import exec_pkg::*; (
    input logic      CLK,
    input logic      arst_n,
    input logic      in_ready,
    input logic      out_valid,
    input logic      out_ready,
    input exec_res_t out_res,
    input dmem_req_t dmem_req,
    input dmem_rsp_t dmem_rsp
);

    int fail_count = 0;                           // read by the testbench

    out_hold: assert property (@(posedge CLK) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_res))
        else begin
            fail_count++;
            $error("completion record changed while out_ready was low");
        end

    rw_excl: assert property (@(posedge CLK) disable iff (!arst_n)
        !(dmem_req.ren && dmem_req.wen))
        else begin
            fail_count++;
            $error("dmem ren and wen high together");
        end

    req_hold: assert property (@(posedge CLK) disable iff (!arst_n)
        (dmem_req.ren || dmem_req.wen) && !dmem_rsp.hit |=> $stable(dmem_req))
        else begin
            fail_count++;
            $error("dmem request changed before hit");
        end

    rst_quiet: assert property (@(posedge CLK)
        !arst_n |-> !out_valid && !in_ready && !dmem_req.ren && !dmem_req.wen
                    && !out_res.redirect)
        else begin
            fail_count++;
            $error("output active during reset");
        end

endmodule

bind exec_top exec_top_asserts u_asserts (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res),
    .dmem_req  (dmem_req),
    .dmem_rsp  (dmem_rsp)
);

// File: tests/exec_top_tb.sv
// 400 instructions from one fixed LFSR seed; lw/sw stay inside a 64-word memory, needs bind support
`timescale 1ns/1ns

module exec_top_tb import exec_pkg::*; ();

    typedef struct packed {
        exec_res_t   res;
        logic        wdata_care;                  // stores leave wdata undefined
        logic        timed;                       // latency phase entry
        logic [31:0] cyc;                         // cycle of acceptance
    } exp_entry_t;

    logic       CLK;
    logic       arst_n;
    logic       in_valid, in_ready;
    issue_pkt_t in_pkt;
    dmem_req_t  dmem_req;
    dmem_rsp_t  dmem_rsp;
    logic       out_valid, out_ready;
    exec_res_t  out_res;

    logic [31:0] lfsr = 32'h0766_5c77;
    logic [31:0] dmem [64];                       // memory behind the dmem port
    logic [31:0] model_mem [64];                  // reference copy, updated in issue order
    exp_entry_t  exp_q [$];
    exp_entry_t  pend;                            // expectation for the packet on in_pkt
    logic        in_fire = 1'b0;
    logic [31:0] cycle = '0;
    int unsigned n_random = 360;                  // mixed traffic, then the latency run
    int unsigned n_total  = 400;
    int unsigned sent = 0;
    int unsigned accepted = 0;
    int unsigned stall_cycles = 0;
    int unsigned drain_cycles = 0;
    int unsigned guard = 0;
    logic [1:0]  gap = '0;
    logic        mem_active = 1'b0;
    logic [2:0]  mem_wait = '0;

    exec_top u_dut (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .dmem_req  (dmem_req),
        .dmem_rsp  (dmem_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    always #10 CLK = ~CLK;                        // 20 ns period

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);               // one step per bit
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [5:0] i);
        fill_word = {i, 2'b01, ~i, 2'b10, i, 2'b11, ~i, 2'b00};
    endfunction

    // add sub and or xor slt sll srl
    function automatic logic [2:0] alu_funct3(input logic [2:0] k);
        case (k)
            3'd0, 3'd1: alu_funct3 = 3'b000;
            3'd2:       alu_funct3 = 3'b111;
            3'd3:       alu_funct3 = 3'b110;
            3'd4:       alu_funct3 = 3'b100;
            3'd5:       alu_funct3 = 3'b010;
            3'd6:       alu_funct3 = 3'b001;
            default:    alu_funct3 = 3'b101;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] k, input logic [31:0] a,
                                            input logic [31:0] b);
        case (k)
            3'd0:    alu_ref = a + b;
            3'd1:    alu_ref = a - b;
            3'd2:    alu_ref = a & b;
            3'd3:    alu_ref = a | b;
            3'd4:    alu_ref = a ^ b;
            3'd5:    alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd6:    alu_ref = a << b[4:0];
            default: alu_ref = a >> b[4:0];
        endcase
    endfunction

    task automatic finish_failed();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic mismatch_error(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        finish_failed();
    endtask

    task automatic report_failure(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        finish_failed();
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else mismatch_error(name, got, exp);
    endtask

    task automatic gen_packet();
        logic [2:0]  cls, k;
        logic [1:0]  bk;
        logic [4:0]  rd, rs1i, rs2i;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [5:0]  widx;
        logic [31:0] immv, target;
        issue_pkt_t  p;
        exp_entry_t  e;
        p            = '0;
        e            = '0;
        e.timed      = (sent >= n_random);
        p.pc         = {30'(rand_bits(30)), 2'b00};
        p.rs1_val    = rand_bits(32);
        p.rs2_val    = rand_bits(32);
        p.pred_taken = 1'(rand_bits(1));
        rs1i         = 5'(rand_bits(5));
        rs2i         = 5'(rand_bits(5));
        rd           = (rand_bits(3) == 0) ? 5'd0 : 5'(rand_bits(5));   // x0 about one in eight
        k            = 3'(rand_bits(3));
        cls          = e.timed ? 3'(rand_bits(2)) : 3'(rand_bits(3));   // latency run is alu only
        case (cls)
            3'd0, 3'd1: begin                     // register alu
                p.instr      = {(k == 3'd1) ? 7'h20 : 7'h00, rs2i, rs1i, alu_funct3(k), rd, op_reg};
                e.res.wdata  = alu_ref(k, p.rs1_val, p.rs2_val);
                e.res.rd_we  = (rd != 5'd0);
                e.wdata_care = 1'b1;
            end
            3'd2, 3'd3: begin                     // immediate alu, no subi
                if (k == 3'd1) k = 3'd0;
                imm12        = (k >= 3'd6) ? {7'd0, 5'(rand_bits(5))} : 12'(rand_bits(12));
                immv         = {{20{imm12[11]}}, imm12};
                p.instr      = {imm12, rs1i, alu_funct3(k), rd, op_imm};
                e.res.wdata  = alu_ref(k, p.rs1_val, immv);
                e.res.rd_we  = (rd != 5'd0);
                e.wdata_care = 1'b1;
            end
            3'd4: begin                           // beq bne blt bge
                bk   = 2'(rand_bits(2));
                boff = {12'(rand_bits(12)), 1'b0};
                if (rand_bits(2) == 0) p.rs2_val = p.rs1_val;   // equal operands now and then
                p.instr = {boff[12], boff[10:5], rs2i, rs1i, bk[1], 1'b0, bk[0],
                           boff[4:1], boff[11], op_branch};
                case (bk)
                    2'd0:    e.res.taken = (p.rs1_val == p.rs2_val);
                    2'd1:    e.res.taken = (p.rs1_val != p.rs2_val);
                    2'd2:    e.res.taken = ($signed(p.rs1_val) < $signed(p.rs2_val));
                    default: e.res.taken = ($signed(p.rs1_val) >= $signed(p.rs2_val));
                endcase
                target            = p.pc + {{19{boff[12]}}, boff};
                e.res.is_branch   = 1'b1;
                e.res.redirect    = (e.res.taken != p.pred_taken);
                e.res.redirect_pc = e.res.taken ? target : p.pc + 32'd4;
            end
            3'd5: begin                           // jal, link is pc + 4
                joff              = {20'(rand_bits(20)), 1'b0};
                p.instr           = {joff[20], joff[10:1], joff[11], joff[19:12], rd, op_jal};
                e.res.is_branch   = 1'b1;
                e.res.taken       = 1'b1;
                e.res.redirect    = !p.pred_taken;
                e.res.redirect_pc = p.pc + {{11{joff[20]}}, joff};
                e.res.wdata       = p.pc + 32'd4;
                e.res.rd_we       = (rd != 5'd0);
                e.wdata_care      = 1'b1;
            end
            default: begin                        // lw or sw, word aligned inside 64 words
                widx      = 6'(rand_bits(6));
                imm12     = {10'(rand_bits(10)), 2'b00};
                immv      = {{20{imm12[11]}}, imm12};
                p.rs1_val = {24'd0, widx, 2'b00} - immv;
                if (cls == 3'd6) begin
                    p.instr      = {imm12, rs1i, 3'b010, rd, op_load};
                    e.res.wdata  = model_mem[widx];
                    e.res.rd_we  = (rd != 5'd0);
                    e.wdata_care = 1'b1;
                end else begin
                    p.instr = {imm12[11:5], rs2i, rs1i, 3'b010, imm12[4:0], op_store};
                    model_mem[widx] = p.rs2_val;  // later loads see it
                end
            end
        endcase
        e.res.pc = p.pc;
        e.res.rd = p.instr.r.rd;                  // imm bits for branches and stores
        in_pkt   = p;
        pend     = e;
    endtask

    task automatic respond_memory();
        if (dmem_rsp.hit) begin
            dmem_rsp.hit = 1'b0;                  // access closed at the last edge
            mem_active   = 1'b0;
        end else if (dmem_req.ren || dmem_req.wen) begin
            assert (dmem_req.addr[1:0] == 2'b00 && dmem_req.addr < 32'd256)
                else report_failure("data memory address is unaligned or outside the 64 words");
            if (!mem_active) begin
                mem_active = 1'b1;
                mem_wait   = 3'(rand_bits(3) % 6);   // 0 to 5 cycles
            end
            if (mem_wait == 3'd0) begin
                dmem_rsp.hit   = 1'b1;
                dmem_rsp.rdata = dmem[dmem_req.addr[7:2]];
                if (dmem_req.wen) dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
            end else begin
                mem_wait--;
            end
        end
    endtask

    task automatic drive_issue();
        if (in_valid && !in_fire) begin
            stall_cycles++;                       // payload held until taken
            assert (stall_cycles < 300) else report_failure("in_ready stayed low for 300 cycles");
        end else begin
            in_valid     = 1'b0;
            stall_cycles = 0;
            if (in_fire) gap = (sent < n_random && rand_bits(1) != 0) ? 2'(rand_bits(2)) : 2'd0;
            if (sent < n_total) begin
                if (gap != 2'd0) begin
                    gap--;
                end else if (sent == n_random && exp_q.size() != 0) begin
                    drain_cycles++;               // pipe empties before the latency run
                    assert (drain_cycles < 300)
                        else report_failure("pipeline did not drain within 300 cycles");
                end else begin
                    gen_packet();
                    in_valid = 1'b1;
                    sent++;
                end
            end
        end
    endtask

    task automatic check_completion();
        exp_entry_t e;
        assert (exp_q.size() != 0)
            else report_failure("a completion arrived with no instruction outstanding");
        e = exp_q.pop_front();
        check_field("pc", out_res.pc, e.res.pc);
        check_field("rd", 32'(out_res.rd), 32'(e.res.rd));
        check_field("rd_we", 32'(out_res.rd_we), 32'(e.res.rd_we));
        check_field("is_branch", 32'(out_res.is_branch), 32'(e.res.is_branch));
        check_field("taken", 32'(out_res.taken), 32'(e.res.taken));
        check_field("redirect", 32'(out_res.redirect), 32'(e.res.redirect));
        if (e.wdata_care) check_field("wdata", out_res.wdata, e.res.wdata);
        if (e.res.is_branch) check_field("redirect_pc", out_res.redirect_pc, e.res.redirect_pc);
        if (e.timed) check_field("accept to completion cycles", cycle - e.cyc, 32'd2);
    endtask

    // handshakes sampled at the edge where they transfer
    always @(posedge CLK) begin
        if (arst_n) begin
            assert (u_dut.u_asserts.fail_count == 0)
                else report_failure("a protocol assertion on the DUT failed");
            if (out_valid && out_ready) check_completion();
            in_fire = in_valid && in_ready;
            if (in_fire) begin
                pend.cyc = cycle;
                exp_q.push_back(pend);
                accepted++;
            end
            cycle++;
        end
    end

    initial begin
        CLK       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_pkt    = '0;
        out_ready = 1'b0;
        dmem_rsp  = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i]      = fill_word(6'(i));
            model_mem[i] = fill_word(6'(i));
        end
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        while ((accepted < n_total || exp_q.size() != 0) && guard < 20000) begin
            @(negedge CLK);
            respond_memory();
            out_ready = (sent >= n_random) ? 1'b1 : (rand_bits(2) != 0);   // ~25% stalls
            drive_issue();
            guard++;
        end
        if (accepted == n_total && exp_q.size() == 0 && u_dut.u_asserts.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else if (u_dut.u_asserts.fail_count != 0) begin
            report_failure("a protocol assertion on the DUT failed");
        end else begin
            report_failure("run did not complete within 20000 cycles");
        end
    end

endmodule

// File: build.f
source/exec_pkg.sv
source/fu_alu.sv
source/fu_branch.sv
source/fu_scalar_ls.sv
source/issue_decode.sv
source/execute.sv
source/writeback_select.sv
source/exec_top.sv
tests/exec_top_asserts.sv
tests/exec_top_tb.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - source/exec_pkg.sv
  - source/fu_alu.sv
  - source/fu_branch.sv
  - source/fu_scalar_ls.sv
  - source/issue_decode.sv
  - source/execute.sv
  - source/writeback_select.sv
  - source/exec_top.sv
  - target: test
    files:
      - tests/exec_top_asserts.sv
      - tests/exec_top_tb.sv
